/* Makefile */
# Verilator build of the switch configuration testbench

VERILATOR ?= verilator
VFLAGS    ?= -j 0
TOP       ?= tb_switch_conf

FILELIST := tb.f
SOURCES  := $(shell cat $(FILELIST))
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when the file list or a source changes
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --timescale 1ns/1ps $(VFLAGS) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status of the binary gives pass or fail
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* conf_memory.sv */
`default_nettype none

module conf_memory (
  input  logic                           clk,
  input  logic                           en_pc_net,
  input  switch_pkg::mem_write_t         mem_write,
  input  logic [switch_pkg::THREAD_W-1:0] rd_thread,
  input  logic [switch_pkg::PC_W-1:0]     rd_pc,
  output switch_pkg::switch_conf_t       rd_data
);

  import switch_pkg::*;

  switch_conf_t          mem [0:MEM_DEPTH-1];
  logic [MEM_ADDR_W-1:0] wr_addr;
  logic [MEM_ADDR_W-1:0] rd_addr;

  assign wr_addr = {mem_write.thread, mem_write.addr};
  assign rd_addr = {rd_thread, rd_pc};

  always_ff @(posedge clk) begin
    if (mem_write.we) begin
      mem[wr_addr] <= mem_write.data;
    end
  end

  // read port stalls together with the program counters
  always_ff @(posedge clk) begin
    if (en_pc_net) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* conf_pkg.sv */
`default_nettype none

package conf_pkg;

  // field widths of one configuration bus word
  localparam int CONF_BUS_W    = 64;
  localparam int CONF_OP_W     = 4;
  localparam int CONF_SWITCH_W = 8;
  localparam int CONF_THREAD_W = 3;
  localparam int CONF_ADDR_W   = 8;
  localparam int CONF_DATA_W   = 24;

  // whatever is left over below the data field
  localparam int CONF_PAD_W = CONF_BUS_W - CONF_OP_W - CONF_SWITCH_W
                            - CONF_THREAD_W - CONF_ADDR_W - CONF_DATA_W;

  // bus commands, any code not listed here is ignored by the readers
  typedef enum logic [CONF_OP_W-1:0] {
    CONF_NOP         = 4'h0,
    CONF_SET_PC_MAX  = 4'h1,
    CONF_SET_PC_LOOP = 4'h2,
    CONF_WRITE_MEM   = 4'h3
  } conf_op_e;

  // one broadcast command word, op sits in the top bits
  // for the two bound commands addr carries the bound value
  typedef struct packed {
    conf_op_e                 op;
    logic [CONF_SWITCH_W-1:0] switch_id;
    logic [CONF_THREAD_W-1:0] thread;
    logic [CONF_ADDR_W-1:0]   addr;
    logic [CONF_DATA_W-1:0]   data;
    logic [CONF_PAD_W-1:0]    pad;
  } conf_word_t;

endpackage

`default_nettype wire

/* conf_reader.sv */
`default_nettype none

module conf_reader #(
  parameter int unsigned SWITCH_NUMBER = 0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  conf_pkg::conf_word_t     conf_bus,
  output switch_pkg::mem_write_t   mem_write,
  output switch_pkg::bound_write_t bound_write
);

  import conf_pkg::*;
  import switch_pkg::*;

  logic                match;
  logic                mem_we_q;
  logic                max_we_q;
  logic                loop_we_q;
  logic [THREAD_W-1:0] thread_q;
  logic [PC_W-1:0]     addr_q;
  switch_conf_t        data_q;

  assign match = (conf_bus.switch_id == CONF_SWITCH_W'(SWITCH_NUMBER));

  // at most one enable goes high per matching word
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_we_q  <= 1'b0;
      max_we_q  <= 1'b0;
      loop_we_q <= 1'b0;
    end else begin
      mem_we_q  <= 1'b0;
      max_we_q  <= 1'b0;
      loop_we_q <= 1'b0;
      if (match) begin
        case (conf_bus.op)
          CONF_SET_PC_MAX:  max_we_q  <= 1'b1;
          CONF_SET_PC_LOOP: loop_we_q <= 1'b1;
          CONF_WRITE_MEM:   mem_we_q  <= 1'b1;
          CONF_NOP:         ;
          default:          ;
        endcase
      end
    end
  end

  // fields only matter while one of the enables is set
  always_ff @(posedge clk) begin
    if (match) begin
      thread_q <= conf_bus.thread;
      addr_q   <= conf_bus.addr;
      data_q   <= switch_conf_t'(conf_bus.data);
    end
  end

  assign mem_write.we     = mem_we_q;
  assign mem_write.thread = thread_q;
  assign mem_write.addr   = addr_q;
  assign mem_write.data   = data_q;

  // bound commands reuse the addr field as the bound value
  assign bound_write.max_we  = max_we_q;
  assign bound_write.loop_we = loop_we_q;
  assign bound_write.thread  = thread_q;
  assign bound_write.value   = addr_q;

endmodule

`default_nettype wire

/* pc_bound_regs.sv */
`default_nettype none

module pc_bound_regs (
  input  logic                                                   clk,
  input  logic                                                   rst,
  input  switch_pkg::bound_write_t                               bound_write,
  output logic [switch_pkg::NUM_THREADS-1:0][switch_pkg::PC_W-1:0] pc_max,
  output logic [switch_pkg::NUM_THREADS-1:0][switch_pkg::PC_W-1:0] pc_loop
);

  import switch_pkg::*;

  logic [NUM_THREADS-1:0] thread_dec;
  logic [NUM_THREADS-1:0] max_en;
  logic [NUM_THREADS-1:0] loop_en;

  assign thread_dec = NUM_THREADS'(1) << bound_write.thread;
  assign max_en     = thread_dec & {NUM_THREADS{bound_write.max_we}};
  assign loop_en    = thread_dec & {NUM_THREADS{bound_write.loop_we}};

  // one max/loop pair per thread, both cleared by reset
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_max  <= '0;
      pc_loop <= '0;
    end else begin
      for (int t = 0; t < NUM_THREADS; t++) begin
        if (max_en[t]) begin
          pc_max[t] <= bound_write.value;
        end
        if (loop_en[t]) begin
          pc_loop[t] <= bound_write.value;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* switch_conf_control.sv */
`default_nettype none

module switch_conf_control #(
  parameter int unsigned SWITCH_NUMBER = 0,
  parameter int unsigned STAGE         = 1
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     en_pc_net,
  input  conf_pkg::conf_word_t     conf_bus,
  output switch_pkg::switch_conf_t switch_conf
);

  import switch_pkg::*;

  mem_write_t                       mem_write;
  bound_write_t                     bound_write;
  logic [NUM_THREADS-1:0][PC_W-1:0] pc_max;
  logic [NUM_THREADS-1:0][PC_W-1:0] pc_loop;
  logic [THREAD_W-1:0]              rd_thread;
  logic [PC_W-1:0]                  rd_pc;
  switch_conf_t                     rd_data;
  switch_conf_t                     out_pipe [0:STAGE+OUT_PIPE_BASE-1];

  conf_reader #(
    .SWITCH_NUMBER(SWITCH_NUMBER)
  ) conf_reader_inst (
    .clk        (clk),
    .rst        (rst),
    .conf_bus   (conf_bus),
    .mem_write  (mem_write),
    .bound_write(bound_write)
  );

  pc_bound_regs pc_bound_regs_inst (
    .clk        (clk),
    .rst        (rst),
    .bound_write(bound_write),
    .pc_max     (pc_max),
    .pc_loop    (pc_loop)
  );

  thread_pc_bank thread_pc_bank_inst (
    .clk      (clk),
    .rst      (rst),
    .en_pc_net(en_pc_net),
    .pc_max   (pc_max),
    .pc_loop  (pc_loop),
    .rd_thread(rd_thread),
    .rd_pc    (rd_pc)
  );

  conf_memory conf_memory_inst (
    .clk      (clk),
    .en_pc_net(en_pc_net),
    .mem_write(mem_write),
    .rd_thread(rd_thread),
    .rd_pc    (rd_pc),
    .rd_data  (rd_data)
  );

  // later stages of the datapath see their configuration later, so the
  // pipe grows by one register per stage
  always_ff @(posedge clk) begin
    if (en_pc_net) begin
      out_pipe[0] <= rd_data;
      for (int i = 1; i < STAGE + OUT_PIPE_BASE; i++) begin
        out_pipe[i] <= out_pipe[i-1];
      end
    end
  end

  assign switch_conf = out_pipe[STAGE+OUT_PIPE_BASE-1];

endmodule

`default_nettype wire

/* switch_conf_top.sv */
`default_nettype none

module switch_conf_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     en_pc_net,
  input  conf_pkg::conf_word_t     conf_bus,
  output switch_pkg::switch_conf_t switch_conf_0,
  output switch_pkg::switch_conf_t switch_conf_1
);

  // both controllers listen to the same broadcast bus
  switch_conf_control #(
    .SWITCH_NUMBER(0),
    .STAGE        (1)
  ) switch_conf_control_0_inst (
    .clk        (clk),
    .rst        (rst),
    .en_pc_net  (en_pc_net),
    .conf_bus   (conf_bus),
    .switch_conf(switch_conf_0)
  );

  switch_conf_control #(
    .SWITCH_NUMBER(1),
    .STAGE        (2)
  ) switch_conf_control_1_inst (
    .clk        (clk),
    .rst        (rst),
    .en_pc_net  (en_pc_net),
    .conf_bus   (conf_bus),
    .switch_conf(switch_conf_1)
  );

endmodule

`default_nettype wire

/* switch_pkg.sv */
`default_nettype none

package switch_pkg;

  localparam int NUM_THREADS = 8;
  localparam int THREAD_W    = 3;
  localparam int PC_W        = 8;

  // memory is addressed by {thread, pc}, 256 words per thread
  localparam int MEM_ADDR_W = THREAD_W + PC_W;
  localparam int MEM_DEPTH  = 1 << MEM_ADDR_W;

  localparam int SEL_W = 3;

  // output delay on top of the stage position of the switch
  localparam int OUT_PIPE_BASE = 3;

  typedef struct packed {
    logic [SEL_W-1:0] sel7;
    logic [SEL_W-1:0] sel6;
    logic [SEL_W-1:0] sel5;
    logic [SEL_W-1:0] sel4;
    logic [SEL_W-1:0] sel3;
    logic [SEL_W-1:0] sel2;
    logic [SEL_W-1:0] sel1;
    logic [SEL_W-1:0] sel0;
  } switch_conf_t;

  typedef struct packed {
    logic                we;
    logic [THREAD_W-1:0] thread;
    logic [PC_W-1:0]     addr;
    switch_conf_t        data;
  } mem_write_t;

  typedef struct packed {
    logic                max_we;
    logic                loop_we;
    logic [THREAD_W-1:0] thread;
    logic [PC_W-1:0]     value;
  } bound_write_t;

endpackage

`default_nettype wire

/* tb.f */
switch_pkg.sv
conf_pkg.sv
conf_reader.sv
pc_bound_regs.sv
thread_pc_bank.sv
conf_memory.sv
switch_conf_control.sv
switch_conf_top.sv
tb_switch_conf.sv

/* tb_switch_conf.sv */
`default_nettype none

module tb_switch_conf;

  timeunit 1ns;
  timeprecision 100ps;

  import conf_pkg::*;
  import switch_pkg::*;

  localparam int unsigned SEED = 32'h97287900;

  // read to output latency is the stage position plus three registers
  localparam int LAT_0 = 1 + 3;
  localparam int LAT_1 = 2 + 3;

  localparam int FILL_TIMEOUT = 64;
  localparam int RUN_LIMIT_NS = 100_000;

  typedef struct packed {
    logic         valid;
    switch_conf_t word;
  } exp_entry_t;

  logic         clk;
  logic         rst;
  logic         en_pc_net;
  conf_word_t   conf_bus;
  switch_conf_t switch_conf_0;
  switch_conf_t switch_conf_1;

  // reference model state, index 0 is switch 0 and index 1 is switch 1
  switch_conf_t model_mem     [0:1][0:2047];
  bit           model_written [0:1][0:2047];
  logic [7:0]   model_max     [0:1][0:7];
  logic [7:0]   model_loop    [0:1][0:7];
  logic [7:0]   model_pc      [0:1][0:7];
  int           model_tc;
  exp_entry_t   pipe_q0 [$];
  exp_entry_t   pipe_q1 [$];
  exp_entry_t   held [0:1];
  int           checks;

  switch_conf_top switch_conf_top_inst (
    .clk          (clk),
    .rst          (rst),
    .en_pc_net    (en_pc_net),
    .conf_bus     (conf_bus),
    .switch_conf_0(switch_conf_0),
    .switch_conf_1(switch_conf_1)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(RUN_LIMIT_NS);
    $display("Error: the run did not finish within its time limit");
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  function automatic conf_word_t make_word(input conf_op_e op, input int sw, input int thread,
                                           input int addr, input logic [CONF_DATA_W-1:0] data);
    conf_word_t w;
    w.op        = op;
    w.switch_id = 8'(sw);
    w.thread    = 3'(thread);
    w.addr      = 8'(addr);
    w.data      = data;
    w.pad       = '0;
    return w;
  endfunction

  // only bound and memory commands for switch 0 or 1 change anything
  function automatic void model_apply(input conf_word_t w);
    int s;
    int a;
    if (w.switch_id == 8'd0) begin
      s = 0;
    end else if (w.switch_id == 8'd1) begin
      s = 1;
    end else begin
      return;
    end
    a = int'(w.thread) * 256 + int'(w.addr);
    case (w.op)
      CONF_SET_PC_MAX:  model_max[s][w.thread] = w.addr;
      CONF_SET_PC_LOOP: model_loop[s][w.thread] = w.addr;
      CONF_WRITE_MEM: begin
        model_mem[s][a]     = switch_conf_t'(w.data);
        model_written[s][a] = 1'b1;
      end
      default: ;
    endcase
  endfunction

  function automatic exp_entry_t model_read(input int s);
    exp_entry_t e;
    int         a;
    a       = model_tc * 256 + int'(model_pc[s][model_tc]);
    e.valid = model_written[s][a];
    e.word  = model_mem[s][a];
    return e;
  endfunction

  // one enabled edge: read, step the current thread, shift the pipes
  function automatic void model_step();
    exp_entry_t rd0;
    exp_entry_t rd1;
    logic [7:0] pc;
    rd0 = model_read(0);
    rd1 = model_read(1);
    for (int s = 0; s < 2; s++) begin
      pc = model_pc[s][model_tc];
      model_pc[s][model_tc] = (pc == model_max[s][model_tc]) ? model_loop[s][model_tc]
                                                            : pc + 8'd1;
    end
    model_tc = (model_tc + 1) % 8;
    pipe_q0.push_back(rd0);
    if (pipe_q0.size() > LAT_0) begin
      held[0] = pipe_q0.pop_front();
    end
    pipe_q1.push_back(rd1);
    if (pipe_q1.size() > LAT_1) begin
      held[1] = pipe_q1.pop_front();
    end
  endfunction

  task automatic compare_switch_conf(input string name, input switch_conf_t expected,
                                     input switch_conf_t actual);
    if (actual !== expected) begin
      $display("Fail %s: expected 0x%h, actual 0x%h", name, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "output mismatch");
    end
    checks++;
  endtask

  // words read from never written locations are not compared
  task automatic check_outputs();
    if (held[0].valid) begin
      compare_switch_conf("switch_conf_0", held[0].word, switch_conf_0);
    end
    if (held[1].valid) begin
      compare_switch_conf("switch_conf_1", held[1].word, switch_conf_1);
    end
  endtask

  // starts and ends on a falling edge, leaves en_pc_net low
  task automatic run_cycles(input int n, input logic en_val);
    for (int i = 0; i < n; i++) begin
      en_pc_net = en_val;
      @(posedge clk);
      if (en_val) begin
        model_step();
      end
      @(negedge clk);
      check_outputs();
    end
    en_pc_net = 1'b0;
  endtask

  task automatic conf_write(input conf_word_t w);
    conf_bus = w;
    @(posedge clk);
    @(negedge clk);
    conf_bus = make_word(CONF_NOP, 0, 0, 0, '0);
    model_apply(w);
  endtask

  task automatic load_thread(input int s, input int t, input int max_v, input int loop_v);
    conf_write(make_word(CONF_SET_PC_MAX, s, t, max_v, '0));
    conf_write(make_word(CONF_SET_PC_LOOP, s, t, loop_v, '0));
    for (int a = 0; a <= max_v; a++) begin
      conf_write(make_word(CONF_WRITE_MEM, s, t, a, 24'($urandom)));
    end
  endtask

  task automatic test_single_thread_loop();
    int start;
    int waited;
    load_thread(0, 0, 5, 2);
    run_cycles(2, 1'b0);
    start  = checks;
    waited = 0;
    while (checks == start) begin
      if (waited == FILL_TIMEOUT) begin
        $display("Error: switch 0 never put out a loaded word after the pipe should have filled");
        $display("Result: FAILED");
        $fatal(1, "pipe fill timeout");
      end
      run_cycles(1, 1'b1);
      waited++;
    end
    run_cycles(120, 1'b1);
  endtask

  task automatic test_interleaved_threads();
    int max_v;
    int loop_v;
    for (int s = 0; s < 2; s++) begin
      for (int t = 0; t < 8; t++) begin
        max_v  = 8 + int'($urandom_range(15, 0));
        loop_v = int'($urandom_range(max_v, 0));
        load_thread(s, t, max_v, loop_v);
      end
    end
    run_cycles(2, 1'b0);
    run_cycles(400, 1'b1);
  endtask

  task automatic test_switch_filtering();
    for (int a = 0; a <= int'(model_max[0][1]); a++) begin
      conf_write(make_word(CONF_WRITE_MEM, 7, 1, a, 24'($urandom)));
    end
    conf_write(make_word(CONF_SET_PC_MAX, 7, 2, 3, '0));
    conf_write(make_word(CONF_SET_PC_LOOP, 7, 2, 1, '0));
    load_thread(1, 6, 23, 4);
    // each ignored word points at an address inside its thread's loop
    conf_write(make_word(CONF_NOP, 0, 0, int'(model_max[0][0]), 24'($urandom)));
    conf_write(make_word(conf_op_e'(4'hA), 0, 0, int'(model_loop[0][0]), 24'($urandom)));
    conf_write(make_word(conf_op_e'(4'hF), 0, 3, int'(model_max[0][3]), 24'($urandom)));
    run_cycles(2, 1'b0);
    run_cycles(300, 1'b1);
  endtask

  task automatic test_stall();
    int n;
    for (int r = 0; r < 3; r++) begin
      run_cycles(37, 1'b1);
      n = 1 + int'($urandom_range(11, 0));
      run_cycles(n, 1'b0);
      run_cycles(100, 1'b1);
    end
  endtask

  task automatic test_reconfig_stalled();
    int new_max;
    run_cycles(29, 1'b1);
    // the new max stays at or above the current PC so the wrap still happens
    new_max = int'(model_pc[0][3]) + 2 + int'($urandom_range(5, 0));
    if (new_max == int'(model_max[0][3])) begin
      new_max++;
    end
    conf_write(make_word(CONF_SET_PC_MAX, 0, 3, new_max, '0));
    for (int a = 0; a <= new_max; a++) begin
      conf_write(make_word(CONF_WRITE_MEM, 0, 3, a, 24'($urandom)));
    end
    for (int a = 0; a <= int'(model_max[1][5]); a++) begin
      conf_write(make_word(CONF_WRITE_MEM, 1, 5, a, 24'($urandom)));
    end
    run_cycles(2, 1'b0);
    run_cycles(300, 1'b1);
  endtask

  initial begin
    void'($urandom(SEED));
    rst       = 1'b1;
    en_pc_net = 1'b0;
    conf_bus  = make_word(CONF_NOP, 0, 0, 0, '0);
    checks    = 0;
    model_tc  = 0;
    held[0]   = '0;
    held[1]   = '0;
    for (int s = 0; s < 2; s++) begin
      for (int t = 0; t < 8; t++) begin
        model_max[s][t]  = 8'd0;
        model_loop[s][t] = 8'd0;
        model_pc[s][t]   = 8'd0;
      end
    end
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
    end
    @(negedge clk);
    rst = 1'b0;

    test_single_thread_loop();
    test_interleaved_threads();
    test_switch_filtering();
    test_stall();
    test_reconfig_stalled();

    if (checks == 0) begin
      $display("Error: no output word was ever compared");
      $display("Result: FAILED");
      $fatal(1, "nothing checked");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* thread_pc_bank.sv */
`default_nettype none

module thread_pc_bank (
  input  logic                                                    clk,
  input  logic                                                    rst,
  input  logic                                                    en_pc_net,
  input  logic [switch_pkg::NUM_THREADS-1:0][switch_pkg::PC_W-1:0] pc_max,
  input  logic [switch_pkg::NUM_THREADS-1:0][switch_pkg::PC_W-1:0] pc_loop,
  output logic [switch_pkg::THREAD_W-1:0]                         rd_thread,
  output logic [switch_pkg::PC_W-1:0]                             rd_pc
);

  import switch_pkg::*;

  logic [THREAD_W-1:0]                thread_q;
  logic [THREAD_W-1:0]                thread_next;
  logic [NUM_THREADS-1:0][PC_W-1:0]   pc_q;
  logic [PC_W-1:0]                    pc_cur;
  logic [PC_W-1:0]                    pc_next;

  assign thread_next = (thread_q == THREAD_W'(NUM_THREADS - 1)) ? '0 : thread_q + 1'b1;

  assign pc_cur = pc_q[thread_q];

  // wrap back to the loop start once the thread reaches its max
  assign pc_next = (pc_cur == pc_max[thread_q]) ? pc_loop[thread_q] : pc_cur + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      thread_q <= '0;
      pc_q     <= '0;
    end else if (en_pc_net) begin
      thread_q         <= thread_next;
      pc_q[thread_q]   <= pc_next;
    end
  end

  // address of the word read at the next enabled edge
  assign rd_thread = thread_q;
  assign rd_pc     = pc_cur;

endmodule

`default_nettype wire
